// ==== src.f ====
+incdir+hw
hw/cn_pkg.sv
hw/param_bank.sv
hw/synapse_current.sv
hw/sensory_path.sv
hw/cortical_path.sv
hw/drive_combiner.sv
hw/cn_drive_top.sv
test/cn_drive_tb.sv

// ==== Bender.yml ====
package:
  name: cn_drive

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cn_pkg.sv
      - hw/param_bank.sv
      - hw/synapse_current.sv
      - hw/sensory_path.sv
      - hw/cortical_path.sv
      - hw/drive_combiner.sv
      - hw/cn_drive_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/cn_drive_tb.sv

// ==== test/cn_drive_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cn_config.svh"

module cn_drive_tb import cn_pkg::*;;

    localparam int TICK_GAP        = 16;     // clocks per sim step
    localparam int WATCHDOG_CYCLES = 20000;

    logic       ep50trig;
    logic       reset_global;
    logic       i_sim_reset;
    logic       i_sim_tick;
    logic       i_spike_ia;
    logic       i_spike_ii;
    logic       i_param_load;
    param_sel_t i_param_sel;
    drive_t     i_param_data;
    logic       i_wave_wr;
    half_t      i_wave_data;
    logic       i_wave_from_value;
    drive_t     o_cn_drive;
    drive_t     o_overflow_drive;

    // reference model state
    sensory_params_t  m_sens;
    cortical_params_t m_cort;
    combiner_params_t m_comb;
    cur_t             m_ia_cur;
    cur_t             m_ii_cur;
    logic             m_ia_pend;
    logic             m_ii_pend;
    drive_t           m_wave [0:`CN_WAVE_DEPTH-1];
    wave_addr_t       m_wr;
    wave_addr_t       m_rd;
    drive_t           m_sample;
    drive_t           exp_drive;     // expected one clock after a tick
    drive_t           exp_ovf;

    int err_count;
    int timeout_count;

    cn_drive_top dut_i (
        .ep50trig          (ep50trig),
        .reset_global      (reset_global),
        .i_sim_reset       (i_sim_reset),
        .i_sim_tick        (i_sim_tick),
        .i_spike_ia        (i_spike_ia),
        .i_spike_ii        (i_spike_ii),
        .i_param_load      (i_param_load),
        .i_param_sel       (i_param_sel),
        .i_param_data      (i_param_data),
        .i_wave_wr         (i_wave_wr),
        .i_wave_data       (i_wave_data),
        .i_wave_from_value (i_wave_from_value),
        .o_cn_drive        (o_cn_drive),
        .o_overflow_drive  (o_overflow_drive)
    );

    initial begin
        ep50trig = 1'b0;
        forever #4 ep50trig = ~ep50trig;   // 8 ns period
    end

    // q16.16 product, 64-bit, bits 47:16 kept
    function automatic logic [31:0] qmul(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] p;
        p = {32'd0, a} * {32'd0, b};
        return p[47:16];
    endfunction

    // weighted sum, shared gain, integer part, compensation
    function automatic drive_t model_sensory();
        logic [63:0] sum;
        logic [63:0] gained;
        logic [63:0] shifted;
        sum     = {32'd0, qmul(m_ia_cur, m_sens.ia_gain)} + {32'd0, qmul(m_ii_cur, m_sens.ii_gain)};
        gained  = {32'd0, qmul(sum[31:0], m_sens.syn_gain)};
        shifted = (gained >> `CN_FRAC_W) << `CN_COMP_SHIFT;
        return shifted[31:0];   // wraps mod 2^32
    endfunction

    // one step, everything from before the tick edge
    function automatic void model_tick(input logic ia_edge, input logic ii_edge);
        logic [63:0] sum;
        logic [63:0] cort;
        cort = ({32'd0, m_cort.tonic} << `CN_TONIC_SHIFT) + {32'd0, m_sample};
        sum  = {32'd0, model_sensory()} + {32'd0, cort[31:0]};
        m_ia_cur  = m_ia_cur - (m_ia_cur >> `CN_SYN_DECAY_SHIFT)
                    + (m_ia_pend ? 32'(`CN_SYN_QUANTUM) : 32'd0);
        m_ii_cur  = m_ii_cur - (m_ii_cur >> `CN_SYN_DECAY_SHIFT)
                    + (m_ii_pend ? 32'(`CN_SYN_QUANTUM) : 32'd0);
        m_ia_pend = ia_edge;    // edge spike waits a step
        m_ii_pend = ii_edge;
        if (i_wave_from_value) begin
            m_sample = m_cort.wave_value;
        end else begin
            m_sample = m_wave[m_rd];
            m_rd     = m_rd + 1'b1;   // 8 bits, wraps at 256
        end
        exp_drive = (sum[31:0] > m_comb.offset) ? sum[31:0] - m_comb.offset : '0;
        exp_ovf   = qmul(exp_drive, m_comb.overflow);
    endfunction

    function automatic void model_sim_reset();
        m_ia_cur  = '0;
        m_ii_cur  = '0;
        m_ia_pend = 1'b0;
        m_ii_pend = 1'b0;
        m_rd      = '0;
        m_sample  = '0;
        exp_drive = '0;
        exp_ovf   = '0;
    endfunction

    // 16 clocks, spike slot -1 means none
    task automatic run_step(input int ia_slot, input int ii_slot,
                            input logic ia_edge, input logic ii_edge);
        for (int c = 0; c < TICK_GAP - 2; c++) begin
            @(negedge ep50trig);
            i_spike_ia = (c == ia_slot);
            i_spike_ii = (c == ii_slot);
            if (c == ia_slot) m_ia_pend = 1'b1;
            if (c == ii_slot) m_ii_pend = 1'b1;
        end
        @(negedge ep50trig);
        i_spike_ia = ia_edge;   // lands on the tick edge
        i_spike_ii = ii_edge;
        i_sim_tick = 1'b1;
        model_tick(ia_edge, ii_edge);
        @(negedge ep50trig);
        i_sim_tick = 1'b0;
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b0;
    endtask

    task automatic idle_steps(input int n);
        for (int k = 0; k < n; k++) begin
            run_step(-1, -1, 1'b0, 1'b0);
        end
    endtask

    task automatic load_param(input param_sel_t sel, input drive_t data);
        @(negedge ep50trig);
        i_param_load = 1'b1;
        i_param_sel  = sel;
        i_param_data = data;
        case (sel)
            param_sel_t'(`CN_SEL_IA_GAIN):    m_sens.ia_gain     = data;
            param_sel_t'(`CN_SEL_II_GAIN):    m_sens.ii_gain     = data;
            param_sel_t'(`CN_SEL_SYN_GAIN):   m_sens.syn_gain    = data;
            param_sel_t'(`CN_SEL_TONIC):      m_cort.tonic       = data;
            param_sel_t'(`CN_SEL_WAVE_VALUE): m_cort.wave_value  = data;
            param_sel_t'(`CN_SEL_OFFSET):     m_comb.offset      = data;
            param_sel_t'(`CN_SEL_OVERFLOW):   m_comb.overflow    = data;
            default: ;
        endcase
        @(negedge ep50trig);
        i_param_load = 1'b0;
    endtask

    task automatic pulse_sim_reset();
        @(negedge ep50trig);
        i_sim_reset = 1'b1;
        model_sim_reset();
        @(negedge ep50trig);
        i_sim_reset = 1'b0;
    endtask

    // two strobes per sample, low half first
    task automatic write_sample(input drive_t value);
        @(negedge ep50trig);
        i_wave_wr   = 1'b1;
        i_wave_data = value[15:0];
        @(negedge ep50trig);
        i_wave_data = value[31:16];
        m_wave[m_wr] = value;
        m_wr         = m_wr + 1'b1;
        @(negedge ep50trig);
        i_wave_wr = 1'b0;
    endtask

    // step until the drive has decayed away
    task automatic wait_drive_zero(input int max_steps);
        int n;
        n = 0;
        while (o_cn_drive != '0 && n < max_steps) begin
            run_step(-1, -1, 1'b0, 1'b0);
            n++;
        end
        if (o_cn_drive != '0) begin
            timeout_count++;
            $display("timeout: drive did not decay to zero within %0d steps", max_steps);
        end
    endtask

    // both outputs against the model, one clock after each tick
    drive_matches_model: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_sim_tick |=> (o_cn_drive == exp_drive)
    ) else begin
        err_count++;
        $display("ERR %0t: o_cn_drive is %0d, model gives %0d",
                 $time, $sampled(o_cn_drive), exp_drive);
    end

    overflow_matches_model: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_sim_tick |=> (o_overflow_drive == exp_ovf)
    ) else begin
        err_count++;
        $display("ERR %0t: o_overflow_drive is %0d, model gives %0d",
                 $time, $sampled(o_overflow_drive), exp_ovf);
    end

    sim_reset_clears_drive: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_sim_reset |=> (o_cn_drive == '0 && o_overflow_drive == '0)
    ) else begin
        err_count++;
        $display("ERR %0t: drive not cleared by sim reset", $time);
    end

    initial begin : watchdog
        for (int n = 0; n < WATCHDOG_CYCLES; n++) begin
            @(posedge ep50trig);
        end
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("errors: %0d check, %0d timeout", err_count, timeout_count + 1);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        int ia_slot;
        int ii_slot;
        void'($urandom(32'h9db8));    // one seed for the whole run
        err_count         = 0;
        timeout_count     = 0;
        reset_global      = 1'b1;
        i_sim_reset       = 1'b0;
        i_sim_tick        = 1'b0;
        i_spike_ia        = 1'b0;
        i_spike_ii        = 1'b0;
        i_param_load      = 1'b0;
        i_param_sel       = '0;
        i_param_data      = '0;
        i_wave_wr         = 1'b0;
        i_wave_data       = '0;
        i_wave_from_value = 1'b0;
        m_sens = '{ia_gain: 32'd65536, ii_gain: 32'd65536, syn_gain: 32'd262144};
        m_cort = '{tonic: '0, wave_value: '0};
        m_comb = '{offset: '0, overflow: 32'd65536};
        m_wr   = '0;
        for (int i = 0; i < `CN_WAVE_DEPTH; i++) begin
            m_wave[i] = '0;   // table powers up empty
        end
        model_sim_reset();
        repeat (2) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;

        // quiet after reset, params survive a sim reset
        idle_steps(8);
        load_param(param_sel_t'(`CN_SEL_TONIC), 32'd5);
        idle_steps(2);
        pulse_sim_reset();
        idle_steps(2);
        load_param(param_sel_t'(`CN_SEL_TONIC), 32'd0);
        pulse_sim_reset();

        // single ia spike, decays with default gains
        run_step(3, -1, 1'b0, 1'b0);
        idle_steps(1);
        wait_drive_zero(64);
        run_step(-1, -1, 1'b1, 1'b0);   // edge spike, seen one step later
        idle_steps(3);
        pulse_sim_reset();

        // random spikes with host gains
        load_param(param_sel_t'(`CN_SEL_IA_GAIN), drive_t'($urandom_range(0, 32'h0004_0000)));
        load_param(param_sel_t'(`CN_SEL_II_GAIN), drive_t'($urandom_range(0, 32'h0004_0000)));
        load_param(param_sel_t'(`CN_SEL_SYN_GAIN), drive_t'($urandom_range(0, 32'h0008_0000)));
        for (int k = 0; k < 40; k++) begin
            ia_slot = $urandom_range(0, 1) ? int'($urandom_range(0, 13)) : -1;
            ii_slot = $urandom_range(0, 1) ? int'($urandom_range(0, 13)) : -1;
            run_step(ia_slot, ii_slot, $urandom_range(0, 7) == 0, $urandom_range(0, 7) == 0);
        end
        load_param(param_sel_t'(`CN_SEL_IA_GAIN), 32'd65536);
        load_param(param_sel_t'(`CN_SEL_II_GAIN), 32'd65536);
        load_param(param_sel_t'(`CN_SEL_SYN_GAIN), 32'd262144);
        pulse_sim_reset();

        // tonic x16, then offset clamp and exact subtract
        load_param(param_sel_t'(`CN_SEL_TONIC), 32'd100);
        idle_steps(2);
        load_param(param_sel_t'(`CN_SEL_OFFSET), 32'd5000);   // above 1600
        idle_steps(2);
        load_param(param_sel_t'(`CN_SEL_OFFSET), 32'd600);
        idle_steps(2);
        run_step(5, 9, 1'b0, 1'b0);
        idle_steps(2);
        load_param(param_sel_t'(`CN_SEL_OFFSET), 32'd0);
        load_param(param_sel_t'(`CN_SEL_TONIC), 32'd0);
        pulse_sim_reset();

        // full table, read back past the wrap
        for (int i = 0; i < `CN_WAVE_DEPTH; i++) begin
            write_sample(drive_t'($urandom));
        end
        idle_steps(`CN_WAVE_DEPTH + 3);
        load_param(param_sel_t'(`CN_SEL_WAVE_VALUE), 32'd1001);
        i_wave_from_value = 1'b1;    // bypass, read pointer holds
        idle_steps(3);
        i_wave_from_value = 1'b0;
        idle_steps(2);

        // overflow proportion 0.5 then 0
        i_wave_from_value = 1'b1;
        load_param(param_sel_t'(`CN_SEL_TONIC), 32'd100);
        load_param(param_sel_t'(`CN_SEL_OVERFLOW), 32'd32768);
        idle_steps(3);   // 2601 halves to 1300
        load_param(param_sel_t'(`CN_SEL_OVERFLOW), 32'd0);
        idle_steps(2);
        load_param(param_sel_t'(`CN_SEL_OVERFLOW), 32'd65536);
        idle_steps(1);
        repeat (2) @(negedge ep50trig);

        $display("errors: %0d check, %0d timeout", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/cn_drive_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cn_drive_top import cn_pkg::*; (
    input  logic       ep50trig,
    input  logic       reset_global,
    input  logic       i_sim_reset,
    input  logic       i_sim_tick,        // one pulse per sim step
    input  logic       i_spike_ia,
    input  logic       i_spike_ii,
    input  logic       i_param_load,
    input  param_sel_t i_param_sel,
    input  drive_t     i_param_data,
    input  logic       i_wave_wr,
    input  half_t      i_wave_data,
    input  logic       i_wave_from_value,
    output drive_t     o_cn_drive,
    output drive_t     o_overflow_drive
);

    sensory_params_t  sensory_params;
    cortical_params_t cortical_params;
    combiner_params_t combiner_params;
    drive_t           sensory_drive;
    drive_t           cortical_drive;

    param_bank param_bank_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_param_load (i_param_load),
        .i_param_sel  (i_param_sel),
        .i_param_data (i_param_data),
        .o_sensory    (sensory_params),
        .o_cortical   (cortical_params),
        .o_combiner   (combiner_params)
    );

    sensory_path sensory_path_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_sim_tick   (i_sim_tick),
        .i_spike_ia   (i_spike_ia),
        .i_spike_ii   (i_spike_ii),
        .i_params     (sensory_params),
        .o_drive      (sensory_drive)
    );

    cortical_path cortical_path_i (
        .ep50trig          (ep50trig),
        .reset_global      (reset_global),
        .i_sim_reset       (i_sim_reset),
        .i_sim_tick        (i_sim_tick),
        .i_wave_wr         (i_wave_wr),
        .i_wave_data       (i_wave_data),
        .i_wave_from_value (i_wave_from_value),
        .i_params          (cortical_params),
        .o_drive           (cortical_drive)
    );

    drive_combiner drive_combiner_i (
        .ep50trig         (ep50trig),
        .reset_global     (reset_global),
        .i_sim_reset      (i_sim_reset),
        .i_sim_tick       (i_sim_tick),
        .i_sensory        (sensory_drive),
        .i_cortical       (cortical_drive),
        .i_params         (combiner_params),
        .o_cn_drive       (o_cn_drive),
        .o_overflow_drive (o_overflow_drive)
    );

endmodule

`default_nettype wire

// ==== hw/drive_combiner.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cn_config.svh"

module drive_combiner import cn_pkg::*; (
    input  logic             ep50trig,
    input  logic             reset_global,
    input  logic             i_sim_reset,
    input  logic             i_sim_tick,
    input  drive_t           i_sensory,    // spindle afferent drive
    input  drive_t           i_cortical,   // tonic + wave
    input  combiner_params_t i_params,
    output drive_t           o_cn_drive,
    output drive_t           o_overflow_drive
);

    drive_t sum_next;
    drive_t sum_q;      // latched once per step
    drive_t clamped;

    assign sum_next = i_sensory + i_cortical;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sum_q <= '0;
        end else if (i_sim_reset) begin
            sum_q <= '0;
        end else if (i_sim_tick) begin
            sum_q <= sum_next;  // values from before this edge
        end
    end

    // offset with a floor at zero
    assign clamped = (sum_q > i_params.offset) ? sum_q - i_params.offset : '0;

    assign o_cn_drive = clamped;

    // overflow neuron gets a proportion of the same drive
    assign o_overflow_drive = q16_mul(clamped, i_params.overflow);

    // the offset only ever takes away
    drive_below_sum: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_cn_drive <= sum_q
    ) else $error("drive_combiner: drive above the latched sum");

endmodule

`default_nettype wire

// ==== hw/cortical_path.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cn_config.svh"

module cortical_path import cn_pkg::*; (
    input  logic             ep50trig,
    input  logic             reset_global,
    input  logic             i_sim_reset,
    input  logic             i_sim_tick,
    input  logic             i_wave_wr,         // host write strobe
    input  half_t            i_wave_data,       // low half first
    input  logic             i_wave_from_value, // bypass the table
    input  cortical_params_t i_params,
    output drive_t           o_drive
);

    drive_t     wave_mem [0:`CN_WAVE_DEPTH-1];
    wave_addr_t wr_ptr;
    wave_addr_t rd_ptr;
    logic       hi_phase;   // next strobe carries the high half
    half_t      lo_half_q;
    drive_t     sample_q;   // current wave sample

    // empty table reads as silence
    initial begin
        for (int i = 0; i < `CN_WAVE_DEPTH; i++) begin
            wave_mem[i] = '0;
        end
    end

    // write side, only a full reset rewinds it
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            wr_ptr    <= '0;
            hi_phase  <= 1'b0;
            lo_half_q <= '0;
        end else if (i_wave_wr) begin
            hi_phase <= ~hi_phase;
            if (!hi_phase) begin
                lo_half_q <= i_wave_data;
            end else begin
                wr_ptr <= (wr_ptr == wave_addr_t'(`CN_WAVE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
        end
    end

    // table storage
    always_ff @(posedge ep50trig) begin
        if (i_wave_wr && hi_phase) begin
            wave_mem[wr_ptr] <= {i_wave_data, lo_half_q};
        end
    end

    // one sample per step
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            rd_ptr   <= '0;
            sample_q <= '0;
        end else if (i_sim_reset) begin
            rd_ptr   <= '0;
            sample_q <= '0;
        end else if (i_sim_tick) begin
            if (i_wave_from_value) begin
                sample_q <= i_params.wave_value;  // pointer holds
            end else begin
                sample_q <= wave_mem[rd_ptr];
                rd_ptr   <= (rd_ptr == wave_addr_t'(`CN_WAVE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // tonic x16 plus the wave
    assign o_drive = (i_params.tonic << `CN_TONIC_SHIFT) + sample_q;

    rd_ptr_in_table: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_sim_tick |=> (rd_ptr < `CN_WAVE_DEPTH)
    ) else $error("cortical_path: read pointer left the table");

endmodule

`default_nettype wire

// ==== hw/sensory_path.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cn_config.svh"

module sensory_path import cn_pkg::*; (
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            i_sim_reset,
    input  logic            i_sim_tick,
    input  logic            i_spike_ia,    // group ia afferent
    input  logic            i_spike_ii,    // group ii afferent
    input  sensory_params_t i_params,
    output drive_t          o_drive
);

    cur_t   ia_cur;
    cur_t   ii_cur;
    cur_t   ia_weighted;
    cur_t   ii_weighted;
    cur_t   chan_sum;
    cur_t   gained;
    drive_t int_part;

    synapse_current syn_ia_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_sim_tick   (i_sim_tick),
        .i_spike      (i_spike_ia),
        .o_current    (ia_cur)
    );

    synapse_current syn_ii_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_sim_tick   (i_sim_tick),
        .i_spike      (i_spike_ii),
        .o_current    (ii_cur)
    );

    // per-channel weighting
    assign ia_weighted = q16_mul(ia_cur, i_params.ia_gain);
    assign ii_weighted = q16_mul(ii_cur, i_params.ii_gain);

    assign chan_sum = ia_weighted + ii_weighted;            // wraps mod 2^32
    assign gained   = q16_mul(chan_sum, i_params.syn_gain); // shared gain

    // drop the fraction, like the old float floor
    assign int_part = drive_t'(gained >> `CN_FRAC_W);

    // scale up for the neuron input range
    assign o_drive = int_part << `CN_COMP_SHIFT;

endmodule

`default_nettype wire

// ==== hw/synapse_current.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cn_config.svh"

module synapse_current import cn_pkg::*; (
    input  logic ep50trig,
    input  logic reset_global,
    input  logic i_sim_reset,   // sync, clears the current
    input  logic i_sim_tick,    // one step
    input  logic i_spike,       // one-clock pulse
    output cur_t o_current
);

    logic spike_pend;   // spike seen since last step
    cur_t current_q;
    cur_t decayed;

    // exponential decay, tau of 8 steps
    assign decayed = current_q - (current_q >> `CN_SYN_DECAY_SHIFT);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            spike_pend <= 1'b0;
            current_q  <= '0;
        end else if (i_sim_reset) begin
            spike_pend <= 1'b0;
            current_q  <= '0;
        end else if (i_sim_tick) begin
            current_q  <= spike_pend ? decayed + cur_t'(`CN_SYN_QUANTUM) : decayed;
            spike_pend <= i_spike;  // spike on the tick edge goes to next step
        end else if (i_spike) begin
            spike_pend <= 1'b1;
        end
    end

    assign o_current = current_q;

    // without a spike the step can only decay
    no_rise_without_spike: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (i_sim_tick && !spike_pend) |=> (o_current <= $past(o_current))
    ) else $error("synapse_current: current rose on a step without a spike");

endmodule

`default_nettype wire

// ==== hw/param_bank.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cn_config.svh"

module param_bank import cn_pkg::*; (
    input  logic             ep50trig,
    input  logic             reset_global,
    input  logic             i_param_load,  // one strobe for every parameter
    input  param_sel_t       i_param_sel,
    input  drive_t           i_param_data,
    output sensory_params_t  o_sensory,
    output cortical_params_t o_cortical,
    output combiner_params_t o_combiner
);

    sensory_params_t  sensory_q;
    cortical_params_t cortical_q;
    combiner_params_t combiner_q;

    // load decode, unknown addresses just fall through
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sensory_q  <= '{ia_gain:  gain_t'(`CN_RST_UNITY_GAIN),
                            ii_gain:  gain_t'(`CN_RST_UNITY_GAIN),
                            syn_gain: gain_t'(`CN_RST_SYN_GAIN)};   // 4.0
            cortical_q <= '{tonic: '0, wave_value: '0};
            combiner_q <= '{offset:   '0,
                            overflow: gain_t'(`CN_RST_UNITY_GAIN)}; // full copy
        end else if (i_param_load) begin
            case (i_param_sel)
                param_sel_t'(`CN_SEL_IA_GAIN):    sensory_q.ia_gain     <= i_param_data;
                param_sel_t'(`CN_SEL_II_GAIN):    sensory_q.ii_gain     <= i_param_data;
                param_sel_t'(`CN_SEL_SYN_GAIN):   sensory_q.syn_gain    <= i_param_data;
                param_sel_t'(`CN_SEL_TONIC):      cortical_q.tonic      <= i_param_data;
                param_sel_t'(`CN_SEL_WAVE_VALUE): cortical_q.wave_value <= i_param_data;
                param_sel_t'(`CN_SEL_OFFSET):     combiner_q.offset     <= i_param_data;
                param_sel_t'(`CN_SEL_OVERFLOW):   combiner_q.overflow   <= i_param_data;
                default: ;  // ignored
            endcase
        end
    end

    // one struct per consumer
    assign o_sensory  = sensory_q;
    assign o_cortical = cortical_q;
    assign o_combiner = combiner_q;

    // an X address on a load would corrupt some register silently
    sel_known_on_load: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_param_load |-> !$isunknown(i_param_sel)
    ) else $error("param_bank: unknown parameter address during load");

endmodule

`default_nettype wire

// ==== hw/cn_pkg.sv ====
`default_nettype none
`include "cn_config.svh"

package cn_pkg;

    // plain vectors, named by what they carry
    typedef logic [`CN_DATA_W-1:0]  cur_t;       // q16.16 synaptic current
    typedef logic [`CN_DATA_W-1:0]  gain_t;      // q16.16 gain
    typedef logic [`CN_DATA_W-1:0]  drive_t;     // integer drive current
    typedef logic [`CN_HALF_W-1:0]  half_t;      // host write word
    typedef logic [`CN_WAVE_AW-1:0] wave_addr_t; // table address
    typedef logic [`CN_SEL_W-1:0]   param_sel_t; // parameter address

    // parameter groups, one per consumer
    typedef struct packed {
        gain_t ia_gain;
        gain_t ii_gain;
        gain_t syn_gain;    // shared gain after the channel sum
    } sensory_params_t;

    typedef struct packed {
        drive_t tonic;
        drive_t wave_value; // sample used when the table is bypassed
    } cortical_params_t;

    typedef struct packed {
        drive_t offset;
        gain_t  overflow;   // 0.0 .. 1.0 proportion
    } combiner_params_t;

    // q16.16 product, unsigned, keeps bits 47:16 of the full result
    function automatic logic [`CN_DATA_W-1:0] q16_mul(input logic [`CN_DATA_W-1:0] a,
                                                      input logic [`CN_DATA_W-1:0] b);
        logic [2*`CN_DATA_W-1:0] prod;
        prod = {{`CN_DATA_W{1'b0}}, a} * {{`CN_DATA_W{1'b0}}, b};
        return prod[`CN_DATA_W+`CN_FRAC_W-1 -: `CN_DATA_W];
    endfunction

endpackage

`default_nettype wire

// ==== hw/cn_config.svh ====
`ifndef CN_CONFIG_SVH
`define CN_CONFIG_SVH

// word widths
`define CN_DATA_W           32      // currents, drives, parameter words
`define CN_FRAC_W           16      // q16.16 fraction bits
`define CN_HALF_W           16      // one host write word

// synapse dynamics
`define CN_SYN_QUANTUM      65536   // 1.0 added per spike
`define CN_SYN_DECAY_SHIFT  3       // i -= i >> 3 each step

// drive scaling
`define CN_COMP_SHIFT       9       // neuron compensation on sensory drive
`define CN_TONIC_SHIFT      4       // tonic drive x16

// waveform table
`define CN_WAVE_DEPTH       256
`define CN_WAVE_AW          8

// host parameter addresses, kept from the old trigger bit numbers
`define CN_SEL_IA_GAIN      1
`define CN_SEL_II_GAIN      2
`define CN_SEL_OVERFLOW     4
`define CN_SEL_OFFSET       6
`define CN_SEL_TONIC        8
`define CN_SEL_WAVE_VALUE   9
`define CN_SEL_SYN_GAIN     13
`define CN_SEL_W            4

// reset values in q16.16
`define CN_RST_UNITY_GAIN   65536   // 1.0
`define CN_RST_SYN_GAIN     262144  // 4.0

`endif
